// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module delay_line_tb -f build.f -o delay_line_sim

run: compile
	@out="$$(./obj_dir/delay_line_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== bench/delay_line_checker.sv ====
`timescale 1ns/1ps

module delay_line_checker
  import delay_line_pkg::*;
(
  input  logic         rd_clk,
  input  logic         user_rst,
  input  logic         start_work,
  input  word_t        wr_data,
  input  logic         wr_data_valid,
  input  word_t        delay_thread,
  input  word_t        rd_data,
  input  logic         rd_data_valid,
  input  logic [127:0] test_name,
  input  int           exp_count,      // golden output word count
  input  logic         end_test,
  input  logic         timed_out,
  output int           tests_run,
  output int           tests_failed,
  output int           error_count
);

  word_t       pending [$];            // accepted, not yet played out
  word_t       want;
  int unsigned accepted;               // since the last reset
  int          out_cnt;
  bit          test_err;
  bit          rst_d;                  // reset seen on the previous edge

  initial
  begin
    tests_run    = 0;
    tests_failed = 0;
    error_count  = 0;
    accepted     = 0;
    out_cnt      = 0;
    test_err     = 1'b0;
    rst_d        = 1'b0;
  end

  task automatic note_failure();
    error_count = error_count + 1;
    test_err    = 1'b1;
  endtask

  always @(posedge rd_clk)
  begin
    if (user_rst)
    begin
      if (!rst_d)
      begin
        pending.delete();              // leftovers of the last test are dropped
        accepted = 0;
        out_cnt  = 0;
        test_err = 1'b0;
      end
      else if (rd_data_valid)
      begin
        $display("test %0s: rd_data_valid high while in reset", test_name);
        note_failure();
      end
    end
    else
    begin
      // ==================================================================
      // output side, oldest accepted word first
      // ==================================================================
      if (rd_data_valid)
      begin
        if (accepted < delay_thread)
        begin
          $display("test %0s: output word before the threshold (%0d of %0d accepted)",
                   test_name, accepted, delay_thread);
          note_failure();
        end
        if (pending.size() == 0)
        begin
          $display("test %0s: output word %0d with no accepted word waiting",
                   test_name, out_cnt);
          note_failure();
        end
        else
        begin
          want = pending.pop_front();
          if (rd_data !== want)
          begin
            $display("Error test %0s word %0d: expected %h, actual %h",
                     test_name, out_cnt, want, rd_data);
            note_failure();
          end
        end
        out_cnt = out_cnt + 1;
      end
      if (wr_data_valid && start_work) // gated words only
      begin
        pending.push_back(wr_data);
        accepted = accepted + 1;
      end
      if (end_test)
      begin
        if (timed_out)
        begin
          $display("test %0s: stimulus or drain did not finish within its cycle limit",
                   test_name);
          note_failure();
        end
        if (out_cnt != exp_count)      // whole bursts only
        begin
          $display("Error test %0s output count: expected %0d, actual %0d",
                   test_name, exp_count, out_cnt);
          note_failure();
        end
        tests_run = tests_run + 1;
        if (test_err)
          tests_failed = tests_failed + 1;
        $display("test %0s: %0d accepted, %0d out, %s", test_name, accepted, out_cnt,
                 test_err ? "FAIL" : "ok");
      end
    end
    rst_d = user_rst;
  end

endmodule

// ==== bench/delay_line_golden.txt ====
# name  delay_thread  words_accepted  idle_mask(hex)  expected_out_words
# idle_mask bit (slot mod 16) set: word offered with start_work low
straight     0    64   0000  64
gated        16   40   0f0f  32
hold         200  48   0000  0
partial      0    70   1248  64
sparse       16   100  aaaa  96
single       16   16   8000  16
short        0    15   0000  0
wrap_stall   200  600  0101  592
after_rst    16   32   0000  32
edge         200  208  0003  208

// ==== bench/delay_line_tb.sv ====
`timescale 1ns/1ps

module delay_line_tb
  import delay_line_pkg::*;
();

  localparam int CLK_PERIOD   = 40;             // ns
  localparam int DRIVE_DLY    = 2;              // ns after rising edge
  localparam int RST_CYCLES   = 3;
  localparam int QUIET_CYCLES = 100;            // silent output ends a drain
  localparam int DRAIN_LIMIT  = 4000;           // cycles per drain
  localparam logic [31:0] LFSR_SEED = 32'd19;

  logic         rd_clk;
  logic         user_rst;
  logic         start_work;
  word_t        wr_data;
  logic         wr_data_valid;
  word_t        delay_thread;
  word_t        rd_data;
  logic         rd_data_valid;

  logic [127:0] test_name;                      // up to 16 characters
  int           exp_count;
  logic         end_test;                       // one cycle, closes a test
  logic         timed_out;
  int           tests_run;
  int           tests_failed;
  int           error_count;

  logic [31:0]  lfsr;                           // data source state
  int           bench_errors;                   // problems outside the checker

  delay_line_top UUT (
    .rd_clk        (rd_clk),
    .user_rst      (user_rst),
    .start_work    (start_work),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .delay_thread  (delay_thread),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

  delay_line_checker score (
    .rd_clk        (rd_clk),
    .user_rst      (user_rst),
    .start_work    (start_work),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .delay_thread  (delay_thread),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .test_name     (test_name),
    .exp_count     (exp_count),
    .end_test      (end_test),
    .timed_out     (timed_out),
    .tests_run     (tests_run),
    .tests_failed  (tests_failed),
    .error_count   (error_count)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #(CLK_PERIOD / 2) rd_clk = ~rd_clk;
  end

  // ======================================================================
  // data source
  // ======================================================================
  // x^32 + x^22 + x^2 + x + 1, shifts toward the msb
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_word(output word_t w);
    w = '0;
    for (int i = 0; i < WORD_W; i++)
    begin
      lfsr = lfsr_next(lfsr);                   // one step per bit
      w    = {w[WORD_W-2:0], lfsr[0]};
    end
  endtask

  // ======================================================================
  // test steps
  // ======================================================================
  task automatic apply_reset(input word_t thr);
    @(posedge rd_clk);
    #(DRIVE_DLY);
    user_rst      = 1'b1;
    start_work    = 1'b0;
    wr_data_valid = 1'b0;
    delay_thread  = thr;                        // settles while in reset
    repeat (RST_CYCLES) @(posedge rd_clk);
    #(DRIVE_DLY);
    user_rst = 1'b0;
  endtask

  // offers words until enough were accepted, idle slots hold start_work low
  task automatic send_words(input int words, input logic [15:0] idle, output bit stuck);
    int         taken;
    int         slot;
    logic [3:0] pos;                            // slot mod 16
    word_t      w;
    taken = 0;
    slot  = 0;
    pos   = '0;
    while (taken < words && slot < words * 4 + 64)
    begin
      @(posedge rd_clk);
      #(DRIVE_DLY);
      next_word(w);
      wr_data       = w;
      wr_data_valid = 1'b1;                     // offered on every slot
      start_work    = !idle[pos];
      if (!idle[pos])
        taken = taken + 1;
      pos  = pos + 4'd1;
      slot = slot + 1;
    end
    @(posedge rd_clk);
    #(DRIVE_DLY);
    wr_data_valid = 1'b0;
    start_work    = 1'b0;
    stuck         = (taken < words);
  endtask

  // waits for a long stretch without output words
  task automatic drain_output(output bit late);
    int cyc;
    int quiet;
    cyc   = 0;
    quiet = 0;
    while (quiet < QUIET_CYCLES && cyc < DRAIN_LIMIT)
    begin
      @(posedge rd_clk);
      #(DRIVE_DLY);
      quiet = rd_data_valid ? 0 : quiet + 1;
      cyc   = cyc + 1;
    end
    late = (quiet < QUIET_CYCLES);
  endtask

  task automatic run_test(input logic [127:0] name, input int thr, input int words,
                          input logic [15:0] idle, input int expected);
    bit stuck;
    bit late;
    test_name = name;
    exp_count = expected;
    apply_reset(word_t'(thr));
    send_words(words, idle, stuck);
    drain_output(late);
    @(posedge rd_clk);
    #(DRIVE_DLY);
    timed_out = stuck || late;
    end_test  = 1'b1;                           // checker reports on this edge
    @(posedge rd_clk);
    #(DRIVE_DLY);
    end_test  = 1'b0;
    timed_out = 1'b0;
  endtask

  // ======================================================================
  // main sequence, one test per golden line
  // ======================================================================
  initial
  begin
    int           fd;
    int           code;
    int           fields;
    logic [767:0] line;
    logic [127:0] name;
    int           thr;
    int           words;
    logic [15:0]  idle;
    int           expected;
    user_rst      = 1'b1;
    start_work    = 1'b0;
    wr_data       = '0;
    wr_data_valid = 1'b0;
    delay_thread  = '0;
    test_name     = '0;
    exp_count     = 0;
    end_test      = 1'b0;
    timed_out     = 1'b0;
    lfsr          = LFSR_SEED;
    bench_errors  = 0;
    fd = $fopen("bench/delay_line_golden.txt", "r");
    if (fd == 0)
    begin
      $display("golden file bench/delay_line_golden.txt could not be opened");
      bench_errors = bench_errors + 1;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line   = '0;
        code   = $fgets(line, fd);
        fields = $sscanf(line, "%s %d %d %h %d", name, thr, words, idle, expected);
        if (code != 0 && fields == 5)             // comment lines give fewer fields
          run_test(name, thr, words, idle, expected);
      end
      $fclose(fd);
    end
    if (tests_run == 0)
    begin
      $display("no test was run from the golden file");
      bench_errors = bench_errors + 1;
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count + bench_errors);
    if (tests_failed == 0 && error_count == 0 && bench_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== build.f ====
verilog/delay_line_pkg.sv
verilog/word_packer.sv
verilog/beat_fifo.sv
verilog/burst_mover.sv
verilog/word_unpacker.sv
verilog/delay_line_top.sv
bench/delay_line_checker.sv
bench/delay_line_tb.sv

// ==== verilog/beat_fifo.sv ====
`timescale 1ns/1ps

module beat_fifo import delay_line_pkg::*;
#(
  parameter int DEPTH = 16       // power of two, pointers wrap freely
)
(
  input  logic      rd_clk,
  input  logic      user_rst,
  input  logic      push,        // write strobe
  input  beat_t     push_data,
  input  logic      pop,         // read strobe, head consumed
  output beat_t     head,        // first word fall through
  output fifo_cnt_t count        // beats held
);

  beat_t                    mem [DEPTH];  // circular storage
  logic [$clog2(DEPTH)-1:0] wr_ptr;       // next free slot
  logic [$clog2(DEPTH)-1:0] rd_ptr;       // oldest beat
  logic                     do_push;
  logic                     do_pop;

  assign do_push = push && (count != fifo_cnt_t'(DEPTH));  // lost when full
  assign do_pop  = pop && (count != '0);                   // no underrun
  assign head    = mem[rd_ptr];                            // valid while count > 0

  always_ff @(posedge rd_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // ======================================================================
  // pointers and occupancy
  // ======================================================================
  always_ff @(posedge rd_clk)
  begin
    if (user_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;        // fill
        2'b01:   count <= count - 1'b1;        // drain
        default: count <= count;               // idle or both
      endcase
    end
  end

endmodule

// ==== verilog/burst_mover.sv ====
`timescale 1ns/1ps

module burst_mover import delay_line_pkg::*;
(
  input  logic      rd_clk,
  input  logic      user_rst,
  input  beat_t     wr_head,       // write fifo head
  input  fifo_cnt_t wr_count,      // write fifo fill
  output logic      wr_pop,        // one pop per write burst beat
  input  fifo_cnt_t rd_count,      // read fifo fill
  output logic      rd_push,       // lags the store read by one cycle
  output beat_t     rd_push_data
);

  typedef enum logic [1:0] {IDLE, WR_BURST, RD_BURST} state_t;
  typedef logic [MEM_AW:0]                  fill_t;   // 0..MEM_BEATS
  typedef logic [$clog2(BURST_LEN)-1:0]     bidx_t;   // beat in burst

  beat_t     store [MEM_BEATS];    // stands in for external memory
  mem_addr_t store_addr;           // next beat written, wraps
  mem_addr_t fetch_addr;           // next beat read, wraps
  fill_t     stored;               // beats waiting in the store
  state_t    state;
  bidx_t     beat_idx;
  logic      last_wr;              // previous burst was a write
  logic      rd_cycle;             // store read this cycle
  logic      wr_ok;                // write burst may start
  logic      rd_ok;                // read burst may start
  fifo_cnt_t rd_free;              // read fifo room incl. pending push

  assign wr_pop   = (state == WR_BURST);
  assign rd_cycle = (state == RD_BURST);

  // the last beat of a read burst is pushed while already idle
  assign rd_free = fifo_cnt_t'(RD_FIFO_DEPTH) - rd_count - fifo_cnt_t'(rd_push);

  assign wr_ok = (wr_count >= fifo_cnt_t'(BURST_LEN))
              && (stored <= fill_t'(MEM_BEATS - BURST_LEN));   // room for a burst
  assign rd_ok = (stored >= fill_t'(BURST_LEN))
              && (rd_free >= fifo_cnt_t'(BURST_LEN));

  // ======================================================================
  // bulk store array
  // ======================================================================
  always_ff @(posedge rd_clk)
  begin
    if (wr_pop)
      store[store_addr] <= wr_head;            // head valid same cycle
    if (rd_cycle)
      rd_push_data <= store[fetch_addr];       // one cycle read
  end

  // ======================================================================
  // burst scheduler
  // ======================================================================
  always_ff @(posedge rd_clk)
  begin
    if (user_rst)
    begin
      state      <= IDLE;
      beat_idx   <= '0;
      last_wr    <= 1'b0;                      // write goes first
      store_addr <= '0;
      fetch_addr <= '0;
      stored     <= '0;
      rd_push    <= 1'b0;
    end
    else
    begin
      rd_push <= rd_cycle;
      case (state)
        IDLE:
        begin
          if (wr_ok && (!last_wr || !rd_ok))   // alternate when both ready
          begin
            state   <= WR_BURST;
            last_wr <= 1'b1;
          end
          else if (rd_ok)
          begin
            state   <= RD_BURST;
            last_wr <= 1'b0;
          end
        end
        default:
        begin
          if (beat_idx == bidx_t'(BURST_LEN - 1))
          begin
            beat_idx <= '0;
            state    <= IDLE;                  // burst done
          end
          else
            beat_idx <= beat_idx + 1'b1;
        end
      endcase
      if (wr_pop)
        store_addr <= store_addr + 1'b1;
      if (rd_cycle)
        fetch_addr <= fetch_addr + 1'b1;
      if (wr_pop)
        stored <= stored + 1'b1;               // never both in one cycle
      else if (rd_cycle)
        stored <= stored - 1'b1;
    end
  end

endmodule

// ==== verilog/delay_line_pkg.sv ====
package delay_line_pkg;

  // ======================================================================
  // stream and beat geometry
  // ======================================================================
  localparam int WORD_W        = 32;                    // one stream word
  localparam int LANES         = 4;                     // words per beat
  localparam int BEAT_W        = WORD_W * LANES;        // 128 bit beat

  // ======================================================================
  // bulk store and queues
  // ======================================================================
  localparam int BURST_LEN     = 4;                     // beats per burst
  localparam int MEM_BEATS     = 64;                    // bulk store depth
  localparam int MEM_AW        = $clog2(MEM_BEATS);     // 6 bit address
  localparam int WR_FIFO_DEPTH = 16;                    // packer side queue
  localparam int RD_FIFO_DEPTH = 8;                     // unpacker side queue
  localparam int CNT_W         = $clog2(WR_FIFO_DEPTH + 1);  // holds 0..16

  typedef logic [WORD_W-1:0]        word_t;             // stream word
  typedef logic [BEAT_W-1:0]        beat_t;             // lane 0 in low bits
  typedef logic [MEM_AW-1:0]        mem_addr_t;         // store address
  typedef logic [CNT_W-1:0]         fifo_cnt_t;         // fifo occupancy
  typedef logic [$clog2(LANES)-1:0] lane_t;             // lane select

endpackage

// ==== verilog/delay_line_top.sv ====
`timescale 1ns/1ps

module delay_line_top import delay_line_pkg::*;
(
  input  logic  rd_clk,
  input  logic  user_rst,
  input  logic  start_work,
  input  word_t wr_data,
  input  logic  wr_data_valid,
  input  word_t delay_thread,
  output word_t rd_data,
  output logic  rd_data_valid
);

  beat_t     beat;               // packer to write fifo
  logic      beat_valid;
  logic      rd_release;         // packer to unpacker
  beat_t     wr_head;            // write fifo to mover
  fifo_cnt_t wr_count;
  logic      wr_pop;
  logic      rd_push;            // mover to read fifo
  beat_t     rd_push_data;
  beat_t     rd_head;            // read fifo to unpacker
  fifo_cnt_t rd_count;
  logic      rd_pop;

  // ======================================================================
  // write side
  // ======================================================================
  word_packer packer (
    .rd_clk        (rd_clk),
    .user_rst      (user_rst),
    .start_work    (start_work),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .delay_thread  (delay_thread),
    .beat          (beat),
    .beat_valid    (beat_valid),
    .rd_release    (rd_release)
  );

  beat_fifo #(.DEPTH(WR_FIFO_DEPTH)) write_fifo (
    .rd_clk    (rd_clk),
    .user_rst  (user_rst),
    .push      (beat_valid),
    .push_data (beat),
    .pop       (wr_pop),
    .head      (wr_head),
    .count     (wr_count)
  );

  // ======================================================================
  // bulk store and read side
  // ======================================================================
  burst_mover mover (
    .rd_clk       (rd_clk),
    .user_rst     (user_rst),
    .wr_head      (wr_head),
    .wr_count     (wr_count),
    .wr_pop       (wr_pop),
    .rd_count     (rd_count),
    .rd_push      (rd_push),
    .rd_push_data (rd_push_data)
  );

  beat_fifo #(.DEPTH(RD_FIFO_DEPTH)) read_fifo (
    .rd_clk    (rd_clk),
    .user_rst  (user_rst),
    .push      (rd_push),
    .push_data (rd_push_data),
    .pop       (rd_pop),
    .head      (rd_head),
    .count     (rd_count)
  );

  word_unpacker unpacker (
    .rd_clk        (rd_clk),
    .user_rst      (user_rst),
    .rd_release    (rd_release),
    .head          (rd_head),
    .count         (rd_count),
    .pop           (rd_pop),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

endmodule

// ==== verilog/word_packer.sv ====
`timescale 1ns/1ps

module word_packer import delay_line_pkg::*;
(
  input  logic  rd_clk,
  input  logic  user_rst,
  input  logic  start_work,      // gates acceptance
  input  word_t wr_data,
  input  logic  wr_data_valid,
  input  word_t delay_thread,    // words to collect before playback
  output beat_t beat,            // packed payload
  output logic  beat_valid,      // one cycle push strobe
  output logic  rd_release       // sticky playback enable
);

  logic  accept;                 // word taken this cycle
  lane_t lane;                   // lanes filled in current beat
  word_t word_cnt;               // accepted words since reset

  assign accept = wr_data_valid && start_work;

  // ======================================================================
  // 4:1 width change
  // ======================================================================
  // new words enter at the top, so after four shifts the first word
  // sits in lane 0
  always_ff @(posedge rd_clk)
  begin
    if (accept)
      beat <= {wr_data, beat[BEAT_W-1:WORD_W]};  // shift down one lane
  end

  always_ff @(posedge rd_clk)
  begin
    if (user_rst)
    begin
      lane       <= '0;
      beat_valid <= 1'b0;
    end
    else
    begin
      beat_valid <= accept && (lane == lane_t'(LANES - 1));  // 4th word in
      if (accept)
        lane <= lane + 1'b1;                   // wraps after last lane
    end
  end

  // ======================================================================
  // word count and read release
  // ======================================================================
  always_ff @(posedge rd_clk)
  begin
    if (user_rst)
    begin
      word_cnt   <= '0;
      rd_release <= 1'b0;
    end
    else
    begin
      if (accept)
        word_cnt <= word_cnt + 1'b1;           // only gated words count
      if (word_cnt >= delay_thread)
        rd_release <= 1'b1;                    // held until reset
    end
  end

endmodule

// ==== verilog/word_unpacker.sv ====
`timescale 1ns/1ps

module word_unpacker import delay_line_pkg::*;
(
  input  logic      rd_clk,
  input  logic      user_rst,
  input  logic      rd_release,     // playback enable
  input  beat_t     head,           // read fifo head
  input  fifo_cnt_t count,          // read fifo fill
  output logic      pop,
  output word_t     rd_data,
  output logic      rd_data_valid
);

  beat_t hold;                      // beat being split
  logic  hold_valid;                // hold has lanes left
  lane_t lane;                      // next lane out
  logic  lane_out;                  // a word leaves this cycle
  logic  lane_last;                 // lane 3 is next

  assign lane_out  = rd_release && hold_valid;
  assign lane_last = (lane == lane_t'(LANES - 1));

  // refill on empty hold or with the last lane so output stays gapless
  assign pop = rd_release && (count != '0) && (!hold_valid || lane_last);

  // ======================================================================
  // 1:4 width change
  // ======================================================================
  always_ff @(posedge rd_clk)
  begin
    if (pop)
      hold <= head;
    if (lane_out)
      rd_data <= hold[lane*WORD_W +: WORD_W];  // lane 0 first
  end

  always_ff @(posedge rd_clk)
  begin
    if (user_rst)
    begin
      hold_valid    <= 1'b0;
      lane          <= '0;
      rd_data_valid <= 1'b0;
    end
    else
    begin
      rd_data_valid <= lane_out;
      if (lane_out)
        lane <= lane + 1'b1;                   // wraps after lane 3
      if (pop)
        hold_valid <= 1'b1;                    // fresh beat
      else if (lane_out && lane_last)
        hold_valid <= 1'b0;                    // beat used up
    end
  end

endmodule
